// ==== src.f ====
+incdir+verilog
+incdir+test
verilog/kyber_pkg.sv
verilog/ct_pkg.sv
verilog/poly_add_u.sv
verilog/poly_add_v.sv
verilog/ct_compress_pack.sv
verilog/kyber_ct_add.sv
test/tb_kyber_ct_add.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps \
  -f src.f \
  --top-module tb_kyber_ct_add \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Done: no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== test/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

// n bits from the operand lfsr, one step per bit
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsr_step(lfsr);
    v    = {v[30:0], lfsr[0]};
  end
  return v;
endfunction

// uniform below q, retake until in range
function automatic coef_t rand_coef();
  logic [31:0] v;
  v = take_bits(`COEF_W);
  while (v >= `KYBER_Q) begin
    v = take_bits(`COEF_W);
  end
  return coef_t'(v);
endfunction

function automatic int mod_add(input int a, input int b);
  return (a + b) % `KYBER_Q;
endfunction

// floor((c*2^d + q/2) / q) mod 2^d
function automatic int compress_d(input int c, input int d);
  int num;
  num = (c << d) + `KYBER_Q / 2;  // q/2 rounds down to 1664
  return (num / `KYBER_Q) % (1 << d);
endfunction

// expected u beat, lane 0 in bits 9:0, top pad bits zero
function automatic logic [31:0] u_beat_ref(input coef_vec_t x, input coef_vec_t e1);
  logic [31:0] word;
  int          cu;
  word = '0;
  for (int k = 0; k < `KYBER_K; k++) begin
    cu   = compress_d(mod_add(int'(x[k]), int'(e1[k])), `KYBER_DU);
    word = word | (32'(cu) << (k * `KYBER_DU));
  end
  return word;
endfunction

// expected v nibble, message bit decompressed to ceil(q/2)
function automatic int v_nib_ref(input coef_t y, input coef_t e2, input logic m);
  int v;
  v = mod_add(int'(y), int'(e2));
  v = mod_add(v, m ? (`KYBER_Q + 1) / 2 : 0);
  return compress_d(v, `KYBER_DV);
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
  if (got !== exp) begin
    $display("Fail %s exp=%h got=%h", name, exp, got);
    errors++;
  end
endtask

`endif

// ==== test/tb_kyber_ct_add.sv ====
`timescale 1ns/10ps
`include "kyber_defines.svh"

module tb_kyber_ct_add;
  import kyber_pkg::*;
  import ct_pkg::*;

  localparam int num_tests      = 5;
  localparam int beats_per_test = `KYBER_N + `KYBER_N / `V_PER_BEAT;
  // roughly three cycles per coefficient covers the stalls of the back-pressure test
  localparam int timeout_cycles = num_tests * `KYBER_N * 3 + 400;

  logic       clk;
  logic       rst;
  logic       in_valid;
  logic       in_ready;
  coef_vec_t  in_x;
  coef_vec_t  in_e1;
  coef_t      in_y;
  coef_t      in_e2;
  logic       in_msg;
  logic       out_valid;
  logic       out_ready;
  ct_beat_t   out_data;
  beat_kind_t out_kind;
  logic       out_last;

  int          errors      = 0;
  int          flow_errors = 0;
  int          beats_seen  = 0;
  int          cycle_count = 0;
  int          coef_idx    = 0;
  logic [15:0] lfsr        = 16'd23;
  logic [15:0] bp_lfsr;
  logic        bp_on;

  logic [33:0] exp_q[$];          // {last, kind, data}
  logic [33:0] exp_beat;
  logic [31:0] exp_vacc;          // v nibbles collected for the next v beat

  logic        reset_seen = 1'b0;
  logic        hold_prev  = 1'b0;
  logic [31:0] prev_data;
  beat_kind_t  prev_kind;
  logic        prev_last;

  `include "tb_ref.svh"

  kyber_ct_add uut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_x      (in_x),
    .in_e1     (in_e1),
    .in_y      (in_y),
    .in_e2     (in_e2),
    .in_msg    (in_msg),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_kind  (out_kind),
    .out_last  (out_last)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // sink side with random stalls while bp_on is set
  initial begin
    bp_lfsr = 16'd23;
    out_ready <= 1'b1;
    forever begin
      @(posedge clk);
      if (bp_on) begin
        bp_lfsr = lfsr_step(bp_lfsr);
        out_ready <= bp_lfsr[0];
      end else begin
        out_ready <= 1'b1;
      end
    end
  end

  // q-1 or 0 half of the time and uniform otherwise
  function automatic coef_t edge_coef();
    logic [31:0] sel;
    sel = take_bits(2);
    if (sel == 0) begin
      return coef_t'(`KYBER_Q - 1);
    end else if (sel == 1) begin
      return '0;
    end
    return rand_coef();
  endfunction

  task automatic make_operands(input int mode, output coef_vec_t x, output coef_vec_t e1,
                               output coef_t y, output coef_t e2, output logic m);
    logic [31:0] bit_m;
    x  = '0;
    e1 = '0;
    y  = '0;
    e2 = '0;
    bit_m = take_bits(1);
    m  = bit_m[0];
    case (mode)
      1: m = 1'b0;
      2: ;  // message bit only
      4: begin
        for (int k = 0; k < `KYBER_K; k++) begin
          x[k]  = edge_coef();
          e1[k] = edge_coef();
        end
        y  = edge_coef();
        e2 = edge_coef();
      end
      default: begin
        for (int k = 0; k < `KYBER_K; k++) begin
          x[k]  = rand_coef();
          e1[k] = rand_coef();
        end
        y  = rand_coef();
        e2 = rand_coef();
      end
    endcase
  endtask

  // expected beats for one accepted coefficient
  task automatic push_expected(input coef_vec_t x, input coef_vec_t e1, input coef_t y,
                               input coef_t e2, input logic m);
    int slot;
    int nib;
    slot = coef_idx % `V_PER_BEAT;
    exp_q.push_back({1'b0, BEAT_U, u_beat_ref(x, e1)});
    nib = v_nib_ref(y, e2, m);
    exp_vacc[slot * `KYBER_DV +: `KYBER_DV] = `KYBER_DV'(nib);
    if (slot == `V_PER_BEAT - 1) begin
      exp_q.push_back({(coef_idx == `KYBER_N - 1), BEAT_V, exp_vacc});
    end
    coef_idx = (coef_idx + 1) % `KYBER_N;
  endtask

  task automatic send_coef(input coef_vec_t x, input coef_vec_t e1, input coef_t y,
                           input coef_t e2, input logic m);
    logic taken;
    in_valid <= 1'b1;
    in_x     <= x;
    in_e1    <= e1;
    in_y     <= y;
    in_e2    <= e2;
    in_msg   <= m;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;  // handshake at the coming rising edge
      @(posedge clk);
    end
    push_expected(x, e1, y, e2, m);
  endtask

  task automatic run_test(input int num, input string name);
    int        err_before;
    int        beats_before;
    coef_vec_t x;
    coef_vec_t e1;
    coef_t     y;
    coef_t     e2;
    logic      m;
    err_before   = errors + flow_errors;
    beats_before = beats_seen;
    bp_on <= (num == 5);
    for (int i = 0; i < `KYBER_N; i++) begin
      make_operands(num, x, e1, y, e2, m);
      send_coef(x, e1, y, e2, m);
    end
    in_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    bp_on <= 1'b0;
    if (beats_seen - beats_before != beats_per_test) begin
      $display("test %0d gave %0d output beats instead of %0d", num,
               beats_seen - beats_before, beats_per_test);
      flow_errors++;
    end
    $display("test %0d (%s): %0d errors", num, name, errors + flow_errors - err_before);
  endtask

  // scoreboard and hold checks on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      reset_seen = 1'b1;
      hold_prev  = 1'b0;
    end else begin
      if (reset_seen) begin
        check_value("in_ready", 32'd1, {31'b0, in_ready});
        check_value("out_valid", 32'd0, {31'b0, out_valid});
        reset_seen = 1'b0;
      end
      if (hold_prev) begin
        if (!out_valid) begin
          $display("out_valid dropped before its beat was taken");
          errors++;
        end else if (out_data != prev_data || out_kind != prev_kind || out_last != prev_last) begin
          $display("output beat changed while out_valid was high and out_ready low");
          errors++;
        end
      end
      if (out_valid && out_ready) begin
        beats_seen++;
        if (exp_q.size() == 0) begin
          $display("output beat arrived while no beat was expected");
          errors++;
        end else begin
          exp_beat = exp_q.pop_front();
          check_value("out_data", exp_beat[31:0], out_data);
          check_value("out_kind", {31'b0, exp_beat[32]}, {31'b0, out_kind});
          check_value("out_last", {31'b0, exp_beat[33]}, {31'b0, out_last});
        end
      end
      hold_prev = out_valid && !out_ready;
      prev_data = out_data;
      prev_kind = out_kind;
      prev_last = out_last;
    end
  end

  initial begin
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    rst      <= 1'b1;
    in_valid <= 1'b0;
    in_x     <= '0;
    in_e1    <= '0;
    in_y     <= '0;
    in_e2    <= '0;
    in_msg   <= 1'b0;
    bp_on    <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    run_test(1, "all-zero polynomials");
    run_test(2, "message only");
    run_test(3, "random operands");
    run_test(4, "edge values");
    run_test(5, "random back-pressure");

    $display("%0d tests, %0d beats, %0d errors", num_tests, beats_seen, errors + flow_errors);
    if (errors + flow_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== verilog/kyber_ct_add.sv ====
`timescale 1ns/10ps

// noise addition and ciphertext compression for one coefficient stream
module kyber_ct_add (
  input  logic                 clk,
  input  logic                 rst,

  // coefficient stream in
  input  logic                 in_valid,
  output logic                 in_ready,
  input  kyber_pkg::coef_vec_t in_x,
  input  kyber_pkg::coef_vec_t in_e1,
  input  kyber_pkg::coef_t     in_y,
  input  kyber_pkg::coef_t     in_e2,
  input  logic                 in_msg,

  // ciphertext stream out
  output logic                 out_valid,
  input  logic                 out_ready,
  output ct_pkg::ct_beat_t     out_data,
  output ct_pkg::beat_kind_t   out_kind,
  output logic                 out_last
);
  import kyber_pkg::*;

  logic      step;   // shared so both adders stay on the same coefficient
  coef_vec_t sum_u;
  coef_t     sum_v;

  poly_add_u u_add_u (
    .clk   (clk),
    .rst   (rst),
    .step  (step),
    .x     (in_x),
    .e1    (in_e1),
    .sum_u (sum_u)
  );

  poly_add_v u_add_v (
    .clk   (clk),
    .rst   (rst),
    .step  (step),
    .y     (in_y),
    .e2    (in_e2),
    .msg   (in_msg),
    .sum_v (sum_v)
  );

  ct_compress_pack u_pack (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .step      (step),
    .sum_u     (sum_u),
    .sum_v     (sum_v),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_kind  (out_kind),
    .out_last  (out_last)
  );

endmodule

// ==== verilog/ct_compress_pack.sv ====
`timescale 1ns/10ps
`include "kyber_defines.svh"

// compresses the adder results into ciphertext beats and runs the stream handshakes
module ct_compress_pack (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  output logic                 in_ready,
  output logic                 step,       // advances both adder registers
  input  kyber_pkg::coef_vec_t sum_u,
  input  kyber_pkg::coef_t     sum_v,
  output logic                 out_valid,
  input  logic                 out_ready,
  output ct_pkg::ct_beat_t     out_data,
  output ct_pkg::beat_kind_t   out_kind,
  output logic                 out_last
);
  import ct_pkg::*;

  // numerator c*2^du + q/2 for the wider of the two compressions
  localparam int num_w     = `COEF_W + `KYBER_DU;
  // shift large enough that the reciprocal divide is exact for every numerator
  localparam int div_shift = num_w + `COEF_W;
  localparam int recip_w   = div_shift - `COEF_W + 1;
  localparam int quot_w    = num_w + recip_w - div_shift;
  localparam int idx_w     = $clog2(`KYBER_N);
  localparam int slot_w    = $clog2(`V_PER_BEAT);

  // ceil(2^div_shift / q)
  localparam logic [recip_w-1:0] recip =
    recip_w'(((64'd1 << div_shift) + `KYBER_Q - 1) / `KYBER_Q);
  localparam logic [num_w-1:0] half_q = num_w'(`KYBER_Q / 2);

  // floor(n / q) by multiply and shift
  function automatic logic [quot_w-1:0] div_q(input logic [num_w-1:0] n);
    logic [num_w+recip_w-1:0] prod;
    prod = n * recip;
    return prod[div_shift +: quot_w];
  endfunction

  logic [`KYBER_K-1:0][num_w-1:0]     num_u;
  logic [`KYBER_K-1:0][quot_w-1:0]    quot_u;
  logic [`KYBER_K-1:0][`KYBER_DU-1:0] cu;     // compressed u lanes
  logic [num_w-1:0]                   num_v;
  logic [quot_w-1:0]                  quot_v;
  logic [`KYBER_DV-1:0]               cv;     // compressed v

  logic                                  stage_valid;  // adder registers hold a live coefficient
  logic                                  v_pend;       // v beat waits behind the u beat
  logic                                  out_free;
  logic                                  load_u;
  logic                                  load_v;
  logic [idx_w-1:0]                      idx;          // index of the next u beat
  logic [`V_PER_BEAT-1:0][`KYBER_DV-1:0] v_acc;

  // compress_d(c) = floor((c*2^d + q/2) / q) mod 2^d
  always_comb begin
    for (int k = 0; k < `KYBER_K; k++) begin
      num_u[k]  = {sum_u[k], {`KYBER_DU{1'b0}}} + half_q;
      quot_u[k] = div_q(num_u[k]);
      cu[k]     = quot_u[k][`KYBER_DU-1:0];  // drops the 2^du wrap bit
    end

    num_v  = {{(`KYBER_DU - `KYBER_DV){1'b0}}, sum_v, {`KYBER_DV{1'b0}}} + half_q;
    quot_v = div_q(num_v);
    cv     = quot_v[`KYBER_DV-1:0];
  end

  // the output register can take a new beat
  assign out_free = !out_valid || out_ready;

  // adders move only when the stage content has somewhere to go
  // a pending v beat takes the output slot for one cycle
  assign step     = out_free && !v_pend;
  assign in_ready = step;
  assign load_u   = step && stage_valid;
  assign load_v   = out_free && v_pend;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
      v_pend      <= 1'b0;
      idx         <= '0;
      v_acc       <= '0;
      out_valid   <= 1'b0;
    end else begin
      if (step) begin
        stage_valid <= in_valid;
      end

      if (load_u) begin
        v_acc[idx[slot_w-1:0]] <= cv;
        idx                    <= idx + 1'b1;
        v_pend                 <= (idx[slot_w-1:0] == {slot_w{1'b1}});  // eighth nibble in
      end else if (load_v) begin
        v_pend <= 1'b0;
      end

      if (out_free) begin
        out_valid <= load_u || load_v;
      end
    end
  end

  // beat contents, only written when a beat is loaded
  always_ff @(posedge clk) begin
    if (load_u) begin
      out_data.u_beat <= '{pad: '0, u: cu};
      out_kind        <= BEAT_U;
      out_last        <= 1'b0;
    end else if (load_v) begin
      // v_acc already holds the nibble written with the last u beat
      out_data.v_beat <= '{v: v_acc};
      out_kind        <= BEAT_V;
      out_last        <= (idx == '0);  // idx wrapped after coefficient N-1
    end
  end

endmodule

// ==== verilog/poly_add_v.sv ====
`timescale 1ns/10ps
`include "kyber_defines.svh"

// v = y + e2 + decompress_1(msg) mod q, one register stage
module poly_add_v (
  input  logic             clk,
  input  logic             rst,
  input  logic             step,
  input  kyber_pkg::coef_t y,
  input  kyber_pkg::coef_t e2,
  input  logic             msg,  // one message bit per coefficient
  output kyber_pkg::coef_t sum_v
);
  import kyber_pkg::*;

  // three operands need two extra bits, max is 2*(q-1) + 1665
  localparam int sum_w = `COEF_W + 2;

  localparam logic [sum_w-1:0] q_wide    = sum_w'(`KYBER_Q);
  localparam logic [sum_w-1:0] half_q_up = sum_w'((`KYBER_Q + 1) / 2);  // 1665

  logic [sum_w-1:0] msg_dec;
  logic [sum_w-1:0] raw;
  logic [sum_w-1:0] once;   // after the first subtraction
  logic [sum_w-1:0] twice;  // after the second subtraction
  coef_t            nxt;

  always_comb begin
    msg_dec = msg ? half_q_up : '0;
    raw     = {{(sum_w - `COEF_W){1'b0}}, y} + {{(sum_w - `COEF_W){1'b0}}, e2} + msg_dec;

    // raw stays below 3q, so two conditional steps are enough
    if (raw >= q_wide) begin
      once = raw - q_wide;
    end else begin
      once = raw;
    end

    if (once >= q_wide) begin
      twice = once - q_wide;
    end else begin
      twice = once;
    end

    nxt = twice[`COEF_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_v <= '0;
    end else if (step) begin
      sum_v <= nxt;
    end
  end

endmodule

// ==== verilog/poly_add_u.sv ====
`timescale 1ns/10ps
`include "kyber_defines.svh"

// u_k = x_k + e1_k mod q for all lanes, one register stage
module poly_add_u (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 step,   // load enable from the packer
  input  kyber_pkg::coef_vec_t x,
  input  kyber_pkg::coef_vec_t e1,
  output kyber_pkg::coef_vec_t sum_u
);
  import kyber_pkg::*;

  localparam logic [`COEF_W:0] q_wide = (`COEF_W + 1)'(`KYBER_Q);

  logic [`KYBER_K-1:0][`COEF_W:0] raw;   // plain sum, one carry bit wider
  logic [`KYBER_K-1:0][`COEF_W:0] wrap;  // raw minus q
  coef_vec_t                      nxt;

  // both operands are below q, so a single subtraction brings the sum back in range
  always_comb begin
    for (int k = 0; k < `KYBER_K; k++) begin
      raw[k]  = {1'b0, x[k]} + {1'b0, e1[k]};
      wrap[k] = raw[k] - q_wide;
      if (raw[k] >= q_wide) begin
        nxt[k] = wrap[k][`COEF_W-1:0];
      end else begin
        nxt[k] = raw[k][`COEF_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_u <= '0;
    end else if (step) begin
      sum_u <= nxt;  // held while the output is stalled
    end
  end

endmodule

// ==== verilog/ct_pkg.sv ====
`include "kyber_defines.svh"

package ct_pkg;

  // tells the sink how to read out_data
  typedef enum logic {
    BEAT_U = 1'b0,
    BEAT_V = 1'b1
  } beat_kind_t;

  // three compressed u lanes, lane 0 at bits 9:0
  typedef struct packed {
    logic [31-`KYBER_K*`KYBER_DU:0]      pad;  // always zero
    logic [`KYBER_K-1:0][`KYBER_DU-1:0] u;
  } u_beat_t;

  // eight compressed v coefficients, earliest in the low nibble
  typedef struct packed {
    logic [`V_PER_BEAT-1:0][`KYBER_DV-1:0] v;
  } v_beat_t;

  // one output word, layout picked by beat_kind_t
  typedef union packed {
    u_beat_t u_beat;
    v_beat_t v_beat;
  } ct_beat_t;

endpackage

// ==== verilog/kyber_pkg.sv ====
`include "kyber_defines.svh"

package kyber_pkg;

  // one reduced coefficient, always below q
  typedef logic [`COEF_W-1:0] coef_t;

  // one coefficient index across the k lanes, lane 0 in the low bits
  typedef coef_t [`KYBER_K-1:0] coef_vec_t;

endpackage

// ==== verilog/kyber_defines.svh ====
`ifndef KYBER_DEFINES_SVH
`define KYBER_DEFINES_SVH

// polynomial ring
`define KYBER_N 256   // coefficients per polynomial
`define KYBER_K 3     // u lanes for k = 3
`define KYBER_Q 3329  // modulus

// coefficient width, enough for 0..q-1
`define COEF_W 12

// ciphertext compression widths
`define KYBER_DU 10
`define KYBER_DV 4

// v nibbles packed into one 32-bit beat
`define V_PER_BEAT (32 / `KYBER_DV)

`endif
